//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = idStageTb
FILELIST  = verilog.f
BUILD_DIR = obj_dir
LOG       = sim.log
FAIL_MSG  = Errors found

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: compile
	@./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "$(FAIL_MSG)" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- src/ctrlDecoder.sv
`include "rvDecode_defines.svh"

module ctrlDecoder import rvDecodePkg::*; (
    input  instrT instr,
    output ctrlT  ctrl,
    output logic  illegal,
    output logic  isEbreak
);

    logic [4:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       lowBitsOk;
    logic       wordOrMul;
    logic       opIllegal;
    logic [3:0] aluOp;

    assign opcode = instr[6:2];
    assign funct3 = instr[14:12];
    assign funct7 = instr[31:25];

    assign lowBitsOk = (instr[1:0] == 2'b11);  // no compressed forms

    // addw..., or mul/div in the 64-bit OP class
    assign wordOrMul = (opcode == `OP_REG32) || ((opcode == `OP_REG) && funct7[0]);

    assign isEbreak = (opcode == `OP_EBREAK) && lowBitsOk;
    assign illegal  = opIllegal || !lowBitsOk;

    always_comb begin
        ctrl       = '0;
        ctrl.memOp = funct3;
        aluOp      = 4'b0000;
        opIllegal  = 1'b0;

        case (opcode)
            `OP_LOAD: begin
                ctrl.regWr    = 1'b1;
                ctrl.aluBSrc  = 2'd2;
                ctrl.memRd    = 1'b1;
                ctrl.memToReg = 1'b1;
                opIllegal     = (funct3 == 3'b111);  // no ldu
            end
            `OP_STORE: begin
                ctrl.aluBSrc = 2'd2;
                ctrl.memWr   = 1'b1;
                opIllegal    = funct3[2];
            end
            `OP_BRANCH: begin
                ctrl.aluBSrc = 2'd0;
                aluOp        = {3'b001, funct3[1]};  // 0011 for unsigned compares
                case (funct3)
                    3'b000:         ctrl.branch = 3'b100;
                    3'b001:         ctrl.branch = 3'b101;
                    3'b100, 3'b110: ctrl.branch = 3'b110;
                    3'b101, 3'b111: ctrl.branch = 3'b111;
                    default:        opIllegal   = 1'b1;
                endcase
            end
            `OP_JAL: begin
                ctrl.regWr   = 1'b1;
                ctrl.aluASrc = 1'b1;
                ctrl.aluBSrc = 2'd1;  // pc + 4 to rd
                ctrl.branch  = 3'b001;
            end
            `OP_JALR: begin
                ctrl.regWr   = 1'b1;
                ctrl.aluASrc = 1'b1;
                ctrl.aluBSrc = 2'd1;
                ctrl.branch  = 3'b010;
                opIllegal    = (funct3 != 3'b000);
            end
            `OP_LUI: begin
                ctrl.regWr   = 1'b1;
                ctrl.aluBSrc = 2'd2;
                aluOp        = 4'b1111;  // pass B
            end
            `OP_AUIPC: begin
                ctrl.regWr   = 1'b1;
                ctrl.aluASrc = 1'b1;
                ctrl.aluBSrc = 2'd2;
            end
            `OP_IMM: begin
                ctrl.regWr   = 1'b1;
                ctrl.aluBSrc = 2'd2;
                aluOp        = {(funct3 == 3'b101) && funct7[5], funct3};
                // funct7[0] is shamt[5] on RV64
                if (funct3 == 3'b001)
                    opIllegal = (funct7[6:1] != 6'b000000);
                else if (funct3 == 3'b101)
                    opIllegal = (funct7[6:1] != 6'b000000) && (funct7[6:1] != 6'b010000);
            end
            `OP_IMM32: begin
                ctrl.regWr   = 1'b1;
                ctrl.aluBSrc = 2'd2;
                aluOp        = {(funct3 == 3'b101) && funct7[5], funct3};
                case (funct3)
                    3'b000:  opIllegal = 1'b0;
                    3'b001:  opIllegal = (funct7 != 7'b0000000);
                    3'b101:  opIllegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
                    default: opIllegal = 1'b1;
                endcase
            end
            `OP_REG: begin
                ctrl.regWr   = 1'b1;
                ctrl.aluBSrc = 2'd0;
                aluOp        = {funct7[5], funct3};
                case (funct7)
                    7'b0000000, 7'b0000001: opIllegal = 1'b0;
                    7'b0100000: opIllegal = !(funct3 inside {3'b000, 3'b101});  // sub, sra
                    default:    opIllegal = 1'b1;
                endcase
            end
            `OP_REG32: begin
                ctrl.regWr   = 1'b1;
                ctrl.aluBSrc = 2'd0;
                aluOp        = {funct7[5], funct3};
                case (funct7)
                    7'b0000000: opIllegal = !(funct3 inside {3'b000, 3'b001, 3'b101});
                    7'b0100000: opIllegal = !(funct3 inside {3'b000, 3'b101});
                    7'b0000001: opIllegal = !(funct3 inside {3'b000, 3'b100, 3'b101,
                                                             3'b110, 3'b111});
                    default:    opIllegal = 1'b1;
                endcase
            end
            `OP_EBREAK: begin
                ctrl.aluBSrc = 2'd1;
                ctrl.branch  = 3'b001;
            end
            default: begin
                opIllegal = 1'b1;  // unknown opcode
            end
        endcase

        ctrl.aluCtr = {wordOrMul, instr[3], aluOp};
    end

endmodule

//--- src/decodeRegister.sv
module decodeRegister import rvDecodePkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      instrValid,
    input  instrT     instr,
    input  ctrlT      ctrl,
    input  immT       imm,
    input  logic      illegal,
    input  logic      isEbreak,
    output decodeOutT dec,
    output logic      outValid,
    output logic      outError,
    output logic      halted
);

    stageStateT state;
    logic       accept;
    ctrlT       safeCtrl;

    assign accept = instrValid && (state == stRun);  // strobes dropped once halted
    assign halted = (state == stHalted);

    // an illegal word must not touch the register file or memory
    always_comb begin
        safeCtrl = ctrl;
        if (illegal) begin
            safeCtrl.regWr = 1'b0;
            safeCtrl.memWr = 1'b0;
            safeCtrl.memRd = 1'b0;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state    <= stRun;
            outValid <= 1'b0;
            outError <= 1'b0;
            dec      <= '0;
        end else begin
            outValid <= accept;
            outError <= accept && illegal;  // pulses with outValid
            if (accept) begin
                dec.ctrl <= safeCtrl;
                dec.imm  <= imm;
                dec.rs1  <= instr[19:15];
                dec.rs2  <= instr[24:20];
                dec.rd   <= instr[11:7];
                if (isEbreak)
                    state <= stHalted;  // held until reset
            end
        end
    end

endmodule

//--- src/idStage.sv
module idStage import rvDecodePkg::*; (
    input  logic      clk,
    input  logic      rstN,
    input  logic      instrValid,
    input  instrT     instr,
    output decodeOutT dec,
    output logic      outValid,
    output logic      outError,
    output logic      halted
);

    ctrlT ctrl;
    immT  imm;
    logic illegal;
    logic isEbreak;

    // both decoders see the same word in parallel
    ctrlDecoder ctrlDec (
        .instr    (instr),
        .ctrl     (ctrl),
        .illegal  (illegal),
        .isEbreak (isEbreak)
    );

    immGen immGenInst (
        .instr (instr),
        .imm   (imm)
    );

    decodeRegister decReg (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .ctrl       (ctrl),
        .imm        (imm),
        .illegal    (illegal),
        .isEbreak   (isEbreak),
        .dec        (dec),
        .outValid   (outValid),
        .outError   (outError),
        .halted     (halted)
    );

endmodule

//--- src/immGen.sv
`include "rvDecode_defines.svh"

module immGen import rvDecodePkg::*; (
    input  instrT instr,
    output immT   imm
);

    localparam logic [2:0] FMT_NONE = 3'd0;
    localparam logic [2:0] FMT_I    = 3'd1;
    localparam logic [2:0] FMT_S    = 3'd2;
    localparam logic [2:0] FMT_B    = 3'd3;
    localparam logic [2:0] FMT_U    = 3'd4;
    localparam logic [2:0] FMT_J    = 3'd5;

    logic [2:0] fmt;
    logic       sgn;

    assign sgn = instr[31];  // every format keeps its sign here

    always_comb begin
        case (instr[6:2])
            `OP_LOAD, `OP_JALR, `OP_IMM,
            `OP_IMM32, `OP_EBREAK:  fmt = FMT_I;
            `OP_STORE:              fmt = FMT_S;
            `OP_BRANCH:             fmt = FMT_B;
            `OP_LUI, `OP_AUIPC:     fmt = FMT_U;
            `OP_JAL:                fmt = FMT_J;
            default:                fmt = FMT_NONE;
        endcase
    end

    always_comb begin
        case (fmt)
            FMT_I: imm = {{(`XLEN-11){sgn}}, instr[30:20]};
            FMT_S: imm = {{(`XLEN-11){sgn}}, instr[30:25], instr[11:7]};
            FMT_B: imm = {{(`XLEN-12){sgn}}, instr[7], instr[30:25], instr[11:8], 1'b0};
            FMT_U: imm = {{(`XLEN-31){sgn}}, instr[30:12], 12'b0};
            FMT_J: imm = {{(`XLEN-20){sgn}}, instr[19:12], instr[20], instr[30:21], 1'b0};
            default: imm = '0;
        endcase
    end

endmodule

//--- src/rvDecodePkg.sv
`include "rvDecode_defines.svh"

package rvDecodePkg;

    typedef logic [31:0]       instrT;
    typedef logic [`XLEN-1:0]  immT;     // sign-extended immediate
    typedef logic [4:0]        regIdxT;

    // [5] word or mul/div, [4] opcode bit 3, [3:0] operation
    typedef logic [5:0]        aluCtrT;

    // 000 none, 001 jal/ebreak, 010 jalr, 1xx conditional
    typedef logic [2:0]        branchT;

    // 0 rs2, 1 constant four, 2 immediate
    typedef logic [1:0]        aluBSrcT;

    typedef logic [2:0]        memOpT;   // same as funct3

    typedef struct packed {
        logic    regWr;
        logic    aluASrc;    // 1 selects pc
        aluBSrcT aluBSrc;
        aluCtrT  aluCtr;
        branchT  branch;
        logic    memWr;
        logic    memRd;
        logic    memToReg;
        memOpT   memOp;
    } ctrlT;

    typedef struct packed {
        ctrlT   ctrl;
        immT    imm;
        regIdxT rs1;
        regIdxT rs2;
        regIdxT rd;
    } decodeOutT;

    typedef enum logic {
        stRun    = 1'b0,
        stHalted = 1'b1
    } stageStateT;

endpackage

//--- src/rvDecode_defines.svh
`ifndef RV_DECODE_DEFINES_SVH
`define RV_DECODE_DEFINES_SVH

// data path width of the core
`define XLEN 64

// major opcodes in instr[6:2]
`define OP_LOAD     5'b00000
`define OP_STORE    5'b01000
`define OP_BRANCH   5'b11000
`define OP_JAL      5'b11011
`define OP_JALR     5'b11001
`define OP_LUI      5'b01101
`define OP_AUIPC    5'b00101
`define OP_IMM      5'b00100
`define OP_IMM32    5'b00110
`define OP_REG      5'b01100
`define OP_REG32    5'b01110
`define OP_EBREAK   5'b11100  // system opcode where only ebreak is handled

`endif

//--- tests/idStageTb.sv
module idStageTb import rvDecodePkg::*; ();

    localparam int MaxTests    = 64;
    localparam int Cols        = 7;   // words per stimulus line
    localparam int ResetCycles = 10;

    logic      clk;
    logic      rstN;
    logic      instrValid;
    instrT     instr;
    decodeOutT dec;
    logic      outValid;
    logic      outError;
    logic      halted;

    logic [63:0] stimMem [0:MaxTests*Cols-1];
    int          numTests;
    int          errorCount;
    int          testErrors;
    int          passCount;
    int          failCount;
    int          cycleCount = 0;
    int          cycleLimit = 1000000;
    integer      seed;
    logic        expHalted;

    idStage UUT (
        .clk        (clk),
        .rstN       (rstN),
        .instrValid (instrValid),
        .instr      (instr),
        .dec        (dec),
        .outValid   (outValid),
        .outError   (outError),
        .halted     (halted)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= cycleLimit) begin
            $display("Timeout after %0d cycles, the test sequence did not finish", cycleCount);
            $display("Errors found");
            $finish;
        end
    end

    task automatic checkImm(input string name, input immT got, input immT exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            testErrors++;
        end
    endtask

    task automatic checkCtrl(input string name, input ctrlT got, input ctrlT exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            testErrors++;
        end
    endtask

    task automatic checkReg(input string name, input regIdxT got, input regIdxT exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            testErrors++;
        end
    endtask

    task automatic checkFlag(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Mismatch at %0t: %s got %b expected %b", $time, name, got, exp);
            testErrors++;
        end
    endtask

    function automatic logic isEbreakWord(input instrT w);
        return w == 32'h0010_0073;
    endfunction

    task automatic reportTest(input string label, input instrT w);
        if (testErrors == 0) begin
            passCount++;
            $display("%s  instr %h  ok", label, w);
        end else begin
            failCount++;
            errorCount += testErrors;
            $display("%s  instr %h  failed with %0d mismatches", label, w, testErrors);
        end
    endtask

    // each line holds instr imm aluCtr branch aluBSrc flags error
    task automatic readExpected(input int k, output instrT w, output immT expImm,
                                output ctrlT expCtrl, output logic expErr);
        int         base;
        logic [4:0] flags;
        base             = k * Cols;
        w                = stimMem[base][31:0];
        expImm           = stimMem[base + 1];
        flags            = stimMem[base + 5][4:0];
        expCtrl.regWr    = flags[4];
        expCtrl.aluASrc  = flags[3];
        expCtrl.aluBSrc  = stimMem[base + 4][1:0];
        expCtrl.aluCtr   = stimMem[base + 2][5:0];
        expCtrl.branch   = stimMem[base + 3][2:0];
        expCtrl.memWr    = flags[2];
        expCtrl.memRd    = flags[1];
        expCtrl.memToReg = flags[0];
        expCtrl.memOp    = w[14:12];  // access size is funct3
        expErr           = stimMem[base + 6][0];
    endtask

    task automatic driveTest(input int k, output logic dropped);
        instrT w;
        w          = stimMem[k * Cols][31:0];
        instr      = w;
        instrValid = 1'b1;
        dropped    = expHalted;
        if (!expHalted && isEbreakWord(w))
            expHalted = 1'b1;
    endtask

    task automatic checkTest(input int k, input logic dropped);
        instrT w;
        immT   expImm;
        ctrlT  expCtrl;
        logic  expErr;
        testErrors = 0;
        readExpected(k, w, expImm, expCtrl, expErr);
        if (dropped) begin
            checkFlag("outValid", outValid, 1'b0);  // stage already halted
        end else begin
            checkFlag("outValid", outValid, 1'b1);
            checkFlag("outError", outError, expErr);
            checkCtrl("dec.ctrl", dec.ctrl, expCtrl);
            checkImm("dec.imm", dec.imm, expImm);
            checkReg("dec.rs1", dec.rs1, w[19:15]);
            checkReg("dec.rs2", dec.rs2, w[24:20]);
            checkReg("dec.rd", dec.rd, w[11:7]);
        end
        checkFlag("halted", halted, expHalted);
        reportTest($sformatf("test %0d", k), w);
    endtask

    task automatic runHaltedStrobes(input int count);
        for (int n = 0; n < count; n++) begin
            @(negedge clk);
            instr      = $random(seed);
            instrValid = 1'b1;
            @(negedge clk);
            instrValid = 1'b0;
            testErrors = 0;
            checkFlag("outValid", outValid, 1'b0);
            checkFlag("halted", halted, 1'b1);
            reportTest($sformatf("halted strobe %0d", n), instr);
        end
    endtask

    initial begin
        logic prevDropped;
        seed        = 32'hf6d9;
        rstN        = 1'b0;
        instrValid  = 1'b0;
        instr       = '0;
        expHalted   = 1'b0;
        prevDropped = 1'b0;
        numTests    = 0;
        errorCount  = 0;
        passCount   = 0;
        failCount   = 0;

        // upper half nonzero marks words past the end of the file
        for (int a = 0; a < MaxTests * Cols; a++)
            stimMem[a] = {32'hFFFF_FFFF, a[31:0]};
        $readmemh("tests/idStage_stim.txt", stimMem);
        while (numTests < MaxTests && stimMem[numTests * Cols][63:32] == 32'h0)
            numTests++;
        if (numTests == 0) begin
            $display("No stimulus lines could be read from the stimulus file");
            errorCount++;
        end
        cycleLimit = ResetCycles + 3 * numTests + 50;

        repeat (ResetCycles) @(negedge clk);
        testErrors = 0;
        checkFlag("outValid", outValid, 1'b0);
        checkFlag("outError", outError, 1'b0);
        checkFlag("halted", halted, 1'b0);
        if (dec !== '0) begin
            $display("Mismatch at %0t: dec got %h expected 0", $time, dec);
            testErrors++;
        end
        reportTest("reset", instr);
        rstN = 1'b1;

        // one strobe per cycle back to back
        for (int i = 0; i < numTests; i++) begin
            @(negedge clk);
            if (i > 0)
                checkTest(i - 1, prevDropped);
            driveTest(i, prevDropped);
        end
        @(negedge clk);
        if (numTests > 0)
            checkTest(numTests - 1, prevDropped);
        instrValid = 1'b0;

        @(negedge clk);
        testErrors = 0;
        checkFlag("outValid", outValid, 1'b0);
        checkFlag("outError", outError, 1'b0);
        reportTest("idle", instr);

        if (expHalted) begin
            runHaltedStrobes(3);
        end else begin
            $display("No ebreak was accepted, so the halt behavior was never exercised");
            errorCount++;
        end

        $display("Tests passed %0d, failed %0d, total errors %0d",
                 passCount, failCount, errorCount);
        if (errorCount == 0)
            $display("No errors");
        else
            $display("Errors found");
        $finish;
    end

endmodule

//--- tests/idStage_assertions.sv
module idStageAssertions import rvDecodePkg::*; (
    input logic      clk,
    input logic      rstN,
    input logic      instrValid,
    input decodeOutT dec,
    input logic      outValid,
    input logic      outError,
    input logic      halted
);

    // the ebreak pulse itself shares the edge that sets halted
    property noPulseWhileHalted;
        @(posedge clk) disable iff (!rstN)
            halted |=> !outValid;
    endproperty

    property errorClearsEnables;
        @(posedge clk) disable iff (!rstN)
            outError |-> !(dec.ctrl.regWr || dec.ctrl.memWr || dec.ctrl.memRd);
    endproperty

    property validFollowsStrobe;
        @(posedge clk) disable iff (!rstN)
            !halted |=> (outValid == $past(instrValid));
    endproperty

    assert property (noPulseWhileHalted)
        else $error("outValid pulsed while the stage was halted");
    assert property (errorClearsEnables)
        else $error("illegal result left a write or memory enable set");
    assert property (validFollowsStrobe)
        else $error("outValid did not follow instrValid by one cycle");

endmodule

bind idStage idStageAssertions chk (
    .clk        (clk),
    .rstN       (rstN),
    .instrValid (instrValid),
    .dec        (dec),
    .outValid   (outValid),
    .outError   (outError),
    .halted     (halted)
);

//--- tests/idStage_stim.txt
// instr imm aluCtr branch aluBSrc flags error, all hex
// flags = {regWr, aluASrc, memWr, memRd, memToReg}
FF853283 FFFFFFFFFFFFFFF8 00 0 2 13 0 // ld x5,-8(x10)
06412083 0000000000000064 00 0 2 13 0 // lw x1,100(x2)
FE71B823 FFFFFFFFFFFFFFF0 00 0 2 04 0 // sd x7,-16(x3)
009202A3 0000000000000005 00 0 2 04 0 // sb x9,5(x4)
FE208EE3 FFFFFFFFFFFFFFFC 02 4 0 00 0 // beq x1,x2,-4
0041E863 0000000000000010 03 6 0 00 0 // bltu x3,x4,16
0062D0E3 0000000000000800 02 7 0 00 0 // bge x5,x6,2048
FF9FF0EF FFFFFFFFFFFFFFF8 10 1 1 18 0 // jal x1,-8
00008067 0000000000000000 00 2 1 18 0 // jalr x0,0(x1)
800001B7 FFFFFFFF80000000 0F 0 2 10 0 // lui x3,0x80000
12345217 0000000012345000 00 0 2 18 0 // auipc x4,0x12345
FFF30293 FFFFFFFFFFFFFFFF 00 0 2 10 0 // addi x5,x6,-1
43F45393 000000000000043F 0D 0 2 10 0 // srai x7,x8,63
7F017093 00000000000007F0 07 0 2 10 0 // andi x1,x2,0x7f0
0055049B 0000000000000005 10 0 2 10 0 // addiw x9,x10,5
4036559B 0000000000000403 1D 0 2 10 0 // sraiw x11,x12,3
003100B3 0000000000000000 00 0 0 10 0 // add x1,x2,x3
40628233 0000000000000000 08 0 0 10 0 // sub x4,x5,x6
029403B3 0000000000000000 20 0 0 10 0 // mul x7,x8,x9
02C5D533 0000000000000000 25 0 0 10 0 // divu x10,x11,x12
40F706BB 0000000000000000 38 0 0 10 0 // subw x13,x14,x15
0328E83B 0000000000000000 36 0 0 10 0 // remw x16,x17,x18
00000001 0000000000000000 00 0 2 01 1 // low bits not 11
0000007F 0000000000000000 10 0 0 00 1 // unknown opcode
00009067 0000000000000000 00 2 1 08 1 // jalr funct3 001
0041A863 0000000000000010 03 0 0 00 1 // branch funct3 010
06417083 0000000000000064 00 0 2 01 1 // load funct3 111
009242A3 0000000000000005 00 0 2 00 1 // store funct3 100
40111093 0000000000000401 01 0 2 00 1 // slli with funct7 0100000
0055249B 0000000000000005 12 0 2 00 1 // op-imm32 funct3 010
40629233 0000000000000000 09 0 0 00 1 // op funct7 0100000 funct3 001
029423BB 0000000000000000 32 0 0 00 1 // op-32 funct7 0000001 funct3 010
00100073 0000000000000001 00 1 1 00 0 // ebreak

//--- verilog.f
+incdir+src
src/rvDecodePkg.sv
src/ctrlDecoder.sv
src/immGen.sv
src/decodeRegister.sv
src/idStage.sv
tests/idStage_assertions.sv
tests/idStageTb.sv
